// File: all.f
+incdir+tests
rtl/rv_pkg.sv
rtl/rv_stage_if.sv
rtl/rv_issue.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_write.sv
rtl/rv_regfile.sv
rtl/rv_backend.sv
tests/tb_rv_backend.sv

// File: rtl/rv_backend.sv
`timescale 1ns/1ps

module rv_backend
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_op_valid,
    input  rv_pkg::op_kind_t  i_op_kind,
    input  rv_pkg::funct3_t   i_op_funct3,
    input  rv_pkg::reg_idx_t  i_op_rd,
    input  rv_pkg::reg_idx_t  i_op_rs1,
    input  rv_pkg::reg_idx_t  i_op_rs2,
    input  rv_pkg::word_t     i_op_imm,
    output logic              o_op_ready,
    output logic              o_wb_valid,
    output rv_pkg::reg_idx_t  o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);

    rv_pkg::reg_idx_t  rs1_idx;
    rv_pkg::reg_idx_t  rs2_idx;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     mem_rdata;
    logic              wr_en;
    rv_pkg::reg_idx_t  wr_rd;
    rv_pkg::word_t     wr_data;

    rv_stage_if iss_ex ();
    rv_stage_if ex_mem ();
    rv_stage_if mem_wb ();

    rv_issue rv_issue_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_kind   (i_op_kind),
        .i_op_funct3 (i_op_funct3),
        .i_op_rd     (i_op_rd),
        .i_op_rs1    (i_op_rs1),
        .i_op_rs2    (i_op_rs2),
        .i_op_imm    (i_op_imm),
        .o_op_ready  (o_op_ready),
        .o_rs1_idx   (rs1_idx),
        .o_rs2_idx   (rs2_idx),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .i_clr_en    (wr_en),         // the write-back frees the scoreboard entry.
        .i_clr_rd    (wr_rd),
        .out         (iss_ex.src)
    );

    rv_execute rv_execute_i (.i_clk(i_clk), .i_rst_n(i_rst_n), .in(iss_ex.dst), .out(ex_mem.src));

    rv_memory rv_memory_i
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .in      (ex_mem.dst),
        .out     (mem_wb.src),
        .o_rdata (mem_rdata)
    );

    rv_write rv_write_i
    (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .in        (mem_wb.dst),
        .i_data    (mem_rdata),
        .o_wr_en   (wr_en),
        .o_wr_rd   (wr_rd),
        .o_wr_data (wr_data)
    );

    rv_regfile rv_regfile_i
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_idx  (rs1_idx),
        .i_rs2_idx  (rs2_idx),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wr_en    (wr_en),
        .i_wr_rd    (wr_rd),
        .i_wr_data  (wr_data)
    );

    assign o_wb_valid = wr_en;
    assign o_wb_rd    = wr_rd;
    assign o_wb_data  = wr_data;

endmodule

// File: rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    rv_stage_if.dst in,
    rv_stage_if.src out
);

    rv_pkg::word_t  op_a;
    rv_pkg::word_t  op_b;
    rv_pkg::word_t  sum;
    rv_pkg::word_t  alu_result;
    logic           less;

    assign op_a = in.result;
    assign op_b = in.operand;
    assign sum  = op_a + op_b;     // shared by add, addi and the address.
    assign less = $signed(op_a) < $signed(op_b);

    always_comb
    begin
        case (in.kind)
            rv_pkg::SUB:
                alu_result = op_a - op_b;
            rv_pkg::AND:
                alu_result = op_a & op_b;
            rv_pkg::OR:
                alu_result = op_a | op_b;
            rv_pkg::XOR:
                alu_result = op_a ^ op_b;
            rv_pkg::SLT:
                alu_result = {31'b0, less};
            default:
                alu_result = sum;
        endcase
    end

    // ##################################################################
    // execute register
    // ##################################################################

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            out.valid <= 1'b0;
        else
            out.valid <= in.valid;
    end

    always_ff @(posedge i_clk)
    begin
        out.kind       <= in.kind;
        out.funct3     <= in.funct3;
        out.rd         <= in.rd;
        out.reg_write  <= in.reg_write;
        out.res_src    <= in.res_src;
        out.result     <= alu_result;
        out.operand    <= op_b;
        out.store_data <= in.store_data;
    end

endmodule

// File: rtl/rv_issue.sv
`timescale 1ns/1ps

module rv_issue
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_op_valid,
    input  rv_pkg::op_kind_t  i_op_kind,
    input  rv_pkg::funct3_t   i_op_funct3,
    input  rv_pkg::reg_idx_t  i_op_rd,
    input  rv_pkg::reg_idx_t  i_op_rs1,
    input  rv_pkg::reg_idx_t  i_op_rs2,
    input  rv_pkg::word_t     i_op_imm,
    output logic              o_op_ready,
    output rv_pkg::reg_idx_t  o_rs1_idx,
    output rv_pkg::reg_idx_t  o_rs2_idx,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    input  logic              i_clr_en,
    input  rv_pkg::reg_idx_t  i_clr_rd,
    rv_stage_if.src           out
);

    logic                           held_valid;
    rv_pkg::op_kind_t               held_kind;
    rv_pkg::funct3_t                held_funct3;
    rv_pkg::reg_idx_t               held_rd;
    rv_pkg::reg_idx_t               held_rs1;
    rv_pkg::reg_idx_t               held_rs2;
    rv_pkg::word_t                  held_imm;
    logic [rv_pkg::REG_COUNT-1:0]   busy;
    logic [rv_pkg::REG_COUNT-1:0]   busy_next;
    logic                           uses_rs2;
    logic                           reg_write;
    logic                           release_op;
    logic                           accept;

    assign uses_rs2   = (held_kind != rv_pkg::ADDI) && (held_kind != rv_pkg::LOAD);
    assign reg_write  = (held_kind != rv_pkg::STORE);

    // a second writer of a busy register waits, so one busy bit tracks one producer.
    assign release_op = held_valid && !busy[held_rs1] && !(uses_rs2 && busy[held_rs2])
                        && !(reg_write && busy[held_rd]);
    assign o_op_ready = !held_valid || release_op;
    assign accept     = i_op_valid && o_op_ready;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            held_valid <= 1'b0;
        else if (accept)
            held_valid <= 1'b1;
        else if (release_op)
            held_valid <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            held_kind   <= i_op_kind;
            held_funct3 <= i_op_funct3;
            held_rd     <= i_op_rd;
            held_rs1    <= i_op_rs1;
            held_rs2    <= i_op_rs2;
            held_imm    <= i_op_imm;
        end
    end

    // ##################################################################
    // busy scoreboard
    // ##################################################################

    always_comb
    begin
        busy_next = busy;
        if (i_clr_en)
            busy_next[i_clr_rd] = 1'b0;
        if (release_op && reg_write && (held_rd != '0))
            busy_next[held_rd] = 1'b1;      // set after clear so it wins.
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            busy <= '0;
        else
            busy <= busy_next;
    end

    assign o_rs1_idx = held_rs1;
    assign o_rs2_idx = held_rs2;

    assign out.valid      = release_op;
    assign out.kind       = held_kind;
    assign out.funct3     = held_funct3;
    assign out.rd         = held_rd;
    assign out.reg_write  = reg_write;
    assign out.res_src    = (held_kind == rv_pkg::LOAD) ? rv_pkg::RES_MEMORY : rv_pkg::RES_ALU;
    assign out.result     = i_rs1_data;
    assign out.operand    = (uses_rs2 && (held_kind != rv_pkg::STORE)) ? i_rs2_data
                                                                       : held_imm;
    assign out.store_data = i_rs2_data;    // stores add the immediate and keep rs2 as data.

endmodule

// File: rtl/rv_memory.sv
`timescale 1ns/1ps

module rv_memory
(
    input  logic           i_clk,
    input  logic           i_rst_n,
    rv_stage_if.dst        in,
    rv_stage_if.src        out,
    output rv_pkg::word_t  o_rdata
);

    rv_pkg::word_t                  ram [rv_pkg::MEM_WORDS];
    logic                           st_valid;
    rv_pkg::op_kind_t               st_kind;
    rv_pkg::funct3_t                st_funct3;
    rv_pkg::word_t                  st_addr;
    rv_pkg::word_t                  st_data;
    logic [rv_pkg::MEM_ADDR_W-1:0]  word_idx;
    logic [3:0]                     lane_mask;
    rv_pkg::word_t                  lane_data;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            st_valid <= 1'b0;
        else
            st_valid <= in.valid;
    end

    always_ff @(posedge i_clk)
    begin
        st_kind          <= in.kind;
        st_funct3        <= in.funct3;
        st_addr          <= in.result;
        st_data          <= in.store_data;
        out.rd           <= in.rd;
        out.reg_write    <= in.reg_write;
        out.res_src      <= in.res_src;
        out.operand      <= in.operand;
    end

    assign word_idx = st_addr[rv_pkg::MEM_ADDR_W+1:2];

    // byte lanes of a store; the address bits below the access size are ignored.
    always_comb
    begin
        case (st_funct3)
            rv_pkg::F3_B:
                lane_mask = 4'b0001 << st_addr[1:0];
            rv_pkg::F3_H:
                lane_mask = st_addr[1] ? 4'b1100 : 4'b0011;
            rv_pkg::F3_W:
                lane_mask = 4'b1111;
            default:
                lane_mask = 4'b0000;
        endcase
        lane_data = (st_funct3 == rv_pkg::F3_W) ? st_data :
                    (st_funct3 == rv_pkg::F3_H) ? {2{st_data[15:0]}} : {4{st_data[7:0]}};
    end

    always_ff @(posedge i_clk)
    begin
        if (st_valid && (st_kind == rv_pkg::STORE))
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (lane_mask[i])
                    ram[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
        o_rdata <= ram[word_idx];   // read lines up with the write stage register.
    end

    assign out.valid      = st_valid;
    assign out.kind       = st_kind;
    assign out.funct3     = st_funct3;
    assign out.result     = st_addr;
    assign out.store_data = st_data;

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

    // ##################################################################
    // widths and sizes
    // ##################################################################

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int REG_COUNT  = 32;
    localparam int MEM_WORDS  = 256;
    localparam int MEM_ADDR_W = 8;    // ram index taken from address bits 9 to 2.

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;

    // ##################################################################
    // load and store access codes
    // ##################################################################

    // these follow the rv32i load/store funct3 field.
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // ##################################################################
    // operation kinds and result source
    // ##################################################################

    typedef enum logic [3:0]
    {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        ADDI,
        LOAD,
        STORE
    } op_kind_t;

    typedef enum logic
    {
        RES_ALU,
        RES_MEMORY
    } res_src_t;

endpackage

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  rv_pkg::reg_idx_t  i_rs1_idx,
    input  rv_pkg::reg_idx_t  i_rs2_idx,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data,
    input  logic              i_wr_en,
    input  rv_pkg::reg_idx_t  i_wr_rd,
    input  rv_pkg::word_t     i_wr_data
);

    rv_pkg::word_t  regs [rv_pkg::REG_COUNT];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (i_wr_en && (i_wr_rd != '0))
        begin
            regs[i_wr_rd] <= i_wr_data;    // x0 stays zero.
        end
    end

    assign o_rs1_data = regs[i_rs1_idx];
    assign o_rs2_data = regs[i_rs2_idx];

endmodule

// File: rtl/rv_stage_if.sv
`timescale 1ns/1ps

interface rv_stage_if;

    logic             valid;
    rv_pkg::op_kind_t kind;
    rv_pkg::funct3_t  funct3;
    rv_pkg::reg_idx_t rd;
    logic             reg_write;
    rv_pkg::res_src_t res_src;
    rv_pkg::word_t    result;      // rs1 value out of issue, alu result or address later.
    rv_pkg::word_t    operand;     // second alu input.
    rv_pkg::word_t    store_data;

    modport src
    (
        output valid, kind, funct3, rd, reg_write, res_src, result, operand, store_data
    );

    modport dst
    (
        input  valid, kind, funct3, rd, reg_write, res_src, result, operand, store_data
    );

endinterface

// File: rtl/rv_write.sv
`timescale 1ns/1ps

module rv_write
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    rv_stage_if.dst           in,
    input  rv_pkg::word_t     i_data,
    output logic              o_wr_en,
    output rv_pkg::reg_idx_t  o_wr_rd,
    output rv_pkg::word_t     o_wr_data
);

    logic              valid;
    rv_pkg::funct3_t   funct3;
    rv_pkg::reg_idx_t  rd;
    logic              reg_write;
    rv_pkg::res_src_t  res_src;
    rv_pkg::word_t     alu_result;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;
    rv_pkg::word_t     load_word;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            valid <= 1'b0;
        else
            valid <= in.valid;
    end

    always_ff @(posedge i_clk)
    begin
        funct3     <= in.funct3;
        rd         <= in.rd;
        reg_write  <= in.reg_write;
        res_src    <= in.res_src;
        alu_result <= in.result;
    end

    // ##################################################################
    // load lane select and extension
    // ##################################################################

    always_comb
    begin
        case (alu_result[1:0])
            2'b00:   load_byte = i_data[7:0];
            2'b01:   load_byte = i_data[15:8];
            2'b10:   load_byte = i_data[23:16];
            default: load_byte = i_data[31:24];
        endcase
        load_half = alu_result[1] ? i_data[31:16] : i_data[15:0];
    end

    always_comb
    begin
        case (funct3)
            rv_pkg::F3_B:  load_word = {{24{load_byte[7]}}, load_byte};
            rv_pkg::F3_H:  load_word = {{16{load_half[15]}}, load_half};
            rv_pkg::F3_W:  load_word = i_data;
            rv_pkg::F3_BU: load_word = {24'b0, load_byte};
            rv_pkg::F3_HU: load_word = {16'b0, load_half};
            default:       load_word = '0;
        endcase
    end

    assign o_wr_data = (res_src == rv_pkg::RES_MEMORY) ? load_word : alu_result;
    assign o_wr_rd   = rd;
    assign o_wr_en   = valid && reg_write;

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and searches the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module tb_rv_backend -f all.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_rv_backend > sim.log 2>&1 || true
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// File: tests/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// ######################################################################
// reference model of the registers, the data memory and write-back order
// ######################################################################

rv_pkg::word_t    model_regs [rv_pkg::REG_COUNT];
rv_pkg::word_t    model_mem [rv_pkg::MEM_WORDS];
rv_pkg::reg_idx_t exp_rd [$];
rv_pkg::word_t    exp_data [$];

// applies one accepted operation in issue order.
task automatic apply_op(input rv_pkg::op_kind_t kind, input rv_pkg::funct3_t f3,
                        input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1,
                        input rv_pkg::reg_idx_t rs2, input rv_pkg::word_t imm);
    rv_pkg::word_t                 a;
    rv_pkg::word_t                 b;
    rv_pkg::word_t                 addr;
    rv_pkg::word_t                 word;
    rv_pkg::word_t                 res;
    logic [7:0]                    byte_val;
    logic [15:0]                   half_val;
    logic [rv_pkg::MEM_ADDR_W-1:0] idx;

    a        = model_regs[rs1];
    b        = model_regs[rs2];
    addr     = a + imm;
    idx      = addr[rv_pkg::MEM_ADDR_W+1:2];
    word     = model_mem[idx];
    byte_val = word[8*addr[1:0] +: 8];
    half_val = word[16*addr[1] +: 16];
    case (kind)
        rv_pkg::ADD:  res = a + b;
        rv_pkg::SUB:  res = a - b;
        rv_pkg::AND:  res = a & b;
        rv_pkg::OR:   res = a | b;
        rv_pkg::XOR:  res = a ^ b;
        rv_pkg::SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_pkg::ADDI: res = a + imm;
        rv_pkg::LOAD:
        begin
            case (f3)
                rv_pkg::F3_B:  res = {{24{byte_val[7]}}, byte_val};
                rv_pkg::F3_H:  res = {{16{half_val[15]}}, half_val};
                rv_pkg::F3_W:  res = word;
                rv_pkg::F3_BU: res = {24'b0, byte_val};
                rv_pkg::F3_HU: res = {16'b0, half_val};
                default:       res = '0;
            endcase
        end
        default:      res = '0;
    endcase
    if (kind == rv_pkg::STORE)
    begin
        case (f3)
            rv_pkg::F3_B: model_mem[idx][8*addr[1:0] +: 8] = b[7:0];
            rv_pkg::F3_H: model_mem[idx][16*addr[1] +: 16] = b[15:0];
            rv_pkg::F3_W: model_mem[idx] = b;
            default:      ;
        endcase
    end
    else
    begin
        exp_rd.push_back(rd);          // x0 writes show on the write-back port as well.
        exp_data.push_back(res);
        if (rd != 5'd0)
            model_regs[rd] = res;
    end
endtask

`endif

// File: tests/tb_rv_backend.sv
`timescale 1ns/1ps

module tb_rv_backend;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_OPS      = 400;
    localparam int TIMEOUT_NS   = (NUM_OPS * 5 + 20) * CLK_PERIOD;
    localparam int WIN_BYTES    = 64;     // loads and stores stay in the first 16 ram words.
    localparam int DRAIN_CYCLES = 20;     // longest stall plus the pipeline, with margin.

    logic             i_clk;
    logic             i_rst_n;
    logic             i_op_valid;
    rv_pkg::op_kind_t i_op_kind;
    rv_pkg::funct3_t  i_op_funct3;
    rv_pkg::reg_idx_t i_op_rd;
    rv_pkg::reg_idx_t i_op_rs1;
    rv_pkg::reg_idx_t i_op_rs2;
    rv_pkg::word_t    i_op_imm;
    logic             o_op_ready;
    logic             o_wb_valid;
    rv_pkg::reg_idx_t o_wb_rd;
    rv_pkg::word_t    o_wb_data;

    integer seed;
    int     cycle_count = 0;
    int     accept_cycle = 0;
    int     stall_cycles = 0;
    int     sent = 0;
    int     errors = 0;

    `include "tb_rv_model.svh"

    rv_backend rv_backend_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_kind   (i_op_kind),
        .i_op_funct3 (i_op_funct3),
        .i_op_rd     (i_op_rd),
        .i_op_rs1    (i_op_rs1),
        .i_op_rs2    (i_op_rs2),
        .i_op_imm    (i_op_imm),
        .o_op_ready  (o_op_ready),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(posedge i_clk)
        cycle_count <= cycle_count + 1;

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic logic in_window(input rv_pkg::word_t value);
        in_window = (value < WIN_BYTES) && (value[1:0] == 2'b00);
    endfunction

    task automatic fail_now();
        errors++;
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            fail_now();
        end
    endtask

    // ##################################################################
    // stimulus
    // ##################################################################

    // called on a rising edge; returns on the edge that accepts the operation.
    task automatic send_op(input rv_pkg::op_kind_t kind, input rv_pkg::funct3_t f3,
                           input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1,
                           input rv_pkg::reg_idx_t rs2, input rv_pkg::word_t imm);
        i_op_valid  <= 1'b1;
        i_op_kind   <= kind;
        i_op_funct3 <= f3;
        i_op_rd     <= rd;
        i_op_rs1    <= rs1;
        i_op_rs2    <= rs2;
        i_op_imm    <= imm;
        @(negedge i_clk);
        while (!o_op_ready)
        begin
            stall_cycles++;
            @(negedge i_clk);
        end
        accept_cycle = cycle_count;
        apply_op(kind, f3, rd, rs1, rs2, imm);
        sent++;
        @(posedge i_clk);
    endtask

    task automatic send_random_op();
        logic [31:0]      rnd;
        logic [31:0]      pick;
        rv_pkg::op_kind_t kind;
        rv_pkg::funct3_t  f3;
        rv_pkg::reg_idx_t rs1;
        rv_pkg::word_t    imm;
        rv_pkg::word_t    target;

        rnd  = next_rand();
        pick = next_rand();
        rs1  = {2'b00, rnd[9:7]};
        imm  = {{20{rnd[31]}}, rnd[31:20]};     // 12-bit signed immediate.
        f3   = rnd[15:13];
        case (rnd[3:0])
            4'd0:               kind = rv_pkg::ADD;
            4'd1:               kind = rv_pkg::SUB;
            4'd2:               kind = rv_pkg::AND;
            4'd3:               kind = rv_pkg::OR;
            4'd4:               kind = rv_pkg::XOR;
            4'd5, 4'd6:         kind = rv_pkg::SLT;
            4'd7, 4'd8:         kind = rv_pkg::ADDI;
            4'd9, 4'd10, 4'd11: kind = rv_pkg::LOAD;
            default:            kind = rv_pkg::STORE;
        endcase
        if ((kind == rv_pkg::LOAD) || (kind == rv_pkg::STORE))
        begin
            if (kind == rv_pkg::STORE)
                f3 = (pick[7:6] == 2'd0) ? rv_pkg::F3_B :
                     (pick[7:6] == 2'd1) ? rv_pkg::F3_H : rv_pkg::F3_W;
            else if (f3 == 3'b011)
                f3 = rv_pkg::F3_W;
            else if (f3[2:1] == 2'b11)
                f3 = {2'b10, f3[0]};
            target = {26'b0, pick[5:0]};
            if (f3[1:0] == 2'b01)
                target[0] = 1'b0;
            else if (f3[1:0] == 2'b10)
                target[1:0] = 2'b00;
            // a base register out of range is set again first, which also makes a hazard.
            if (!in_window(model_regs[rs1]))
                send_op(rv_pkg::ADDI, rv_pkg::F3_W, rs1, 5'd0, 5'd0, {26'b0, pick[11:8], 2'b00});
            imm = target - model_regs[rs1];
        end
        send_op(kind, f3, {2'b00, rnd[6:4]}, rs1, {2'b00, rnd[12:10]}, imm);
    endtask

    // ##################################################################
    // write-back monitor and watchdog
    // ##################################################################

    always @(negedge i_clk)
    begin
        if (i_rst_n && o_wb_valid)
        begin
            if (exp_rd.size() == 0)
            begin
                $display("ERROR: a write-back arrived at %0t ns with nothing expected", $time);
                fail_now();
            end
            else
            begin
                check("o_wb_rd", {27'b0, o_wb_rd}, {27'b0, exp_rd.pop_front()});
                check("o_wb_data", o_wb_data, exp_data.pop_front());
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("TIMEOUT: the run did not finish within %0d ns", TIMEOUT_NS);
        fail_now();
    end

    initial
    begin
        logic [31:0] rnd;

        seed        = 32'h5def;
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_op_valid  = 1'b0;
        i_op_kind   = rv_pkg::ADD;
        i_op_funct3 = '0;
        i_op_rd     = '0;
        i_op_rs1    = '0;
        i_op_rs2    = '0;
        i_op_imm    = '0;
        for (int i = 0; i < rv_pkg::REG_COUNT; i++)
            model_regs[i] = '0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check("o_wb_valid after reset", {31'b0, o_wb_valid}, 32'd0);
        check("o_op_ready after reset", {31'b0, o_op_ready}, 32'd1);

        // a lone operation on an empty pipeline.
        @(posedge i_clk);
        send_op(rv_pkg::ADDI, rv_pkg::F3_W, 5'd1, 5'd0, 5'd0, 32'd16);
        i_op_valid <= 1'b0;
        do
            @(negedge i_clk);
        while (!o_wb_valid);
        check("cycles from accept to write-back", cycle_count - accept_cycle, 32'd4);

        @(posedge i_clk);
        send_op(rv_pkg::ADDI, rv_pkg::F3_W, 5'd0, 5'd0, 5'd0, 32'd123);
        i_op_valid <= 1'b0;
        while (exp_rd.size() != 0)
            @(negedge i_clk);
        @(posedge i_clk);
        send_op(rv_pkg::ADD, rv_pkg::F3_W, 5'd2, 5'd0, 5'd0, 32'd0);   // x0 reads as zero.
        for (int i = 1; i < 8; i++)
        begin
            rnd = next_rand();
            send_op(rv_pkg::ADDI, rv_pkg::F3_W, rv_pkg::reg_idx_t'(i), 5'd0, 5'd0,
                    {{20{rnd[11]}}, rnd[11:0]});
        end
        // fill the load window so that no load sees an unwritten word.
        for (int i = 0; i < WIN_BYTES / 4; i++)
            send_op(rv_pkg::STORE, rv_pkg::F3_W, 5'd0, 5'd0, rv_pkg::reg_idx_t'(1 + i % 7),
                    rv_pkg::word_t'(4 * i));
        while (sent < NUM_OPS)
            send_random_op();

        i_op_valid <= 1'b0;
        for (int i = 0; (i < DRAIN_CYCLES) && (exp_rd.size() != 0); i++)
            @(negedge i_clk);
        repeat (8) @(negedge i_clk);
        check("expected queue size", exp_rd.size(), 32'd0);
        check("stall seen", (stall_cycles > 0) ? 32'd1 : 32'd0, 32'd1);
        if (errors == 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            fail_now();
        end
    end

endmodule
